// File: hdc_bundler.f
design/hdc_pkg.sv
design/axil_pkg.sv
design/acc_bus_if.sv
design/bundle_bank.sv
design/acc_arbiter.sv
design/axil_regs.sv
design/vector_streamer.sv
design/hdc_bundler.sv
verif/clk_gen.sv
verif/hdc_bundler_tb.sv

// File: Makefile
TOP := hdc_bundler_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f hdc_bundler.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/hdc_bundler_tb.sv
`default_nettype none

module hdc_bundler_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // cycles any single wait may take
    localparam int TIMEOUT = 200;
    // counter range from the counter width
    localparam int CNT_HI  = 2 ** (hdc_pkg::CNT_W - 1) - 1;
    localparam int CNT_LO  = -(2 ** (hdc_pkg::CNT_W - 1));

    logic                        clk;
    logic                        rst_n;
    logic [axil_pkg::ADDR_W-1:0] s_awaddr;
    logic                        s_awvalid;
    logic                        s_awready;
    logic [hdc_pkg::WORD-1:0]    s_wdata;
    logic [hdc_pkg::WORD/8-1:0]  s_wstrb;
    logic                        s_wvalid;
    logic                        s_wready;
    logic [1:0]                  s_bresp;
    logic                        s_bvalid;
    logic                        s_bready;
    logic [axil_pkg::ADDR_W-1:0] s_araddr;
    logic                        s_arvalid;
    logic                        s_arready;
    logic [hdc_pkg::WORD-1:0]    s_rdata;
    logic [1:0]                  s_rresp;
    logic                        s_rvalid;
    logic                        s_rready;
    logic [hdc_pkg::WORD-1:0]    m_tdata;
    logic                        m_tvalid;
    logic                        m_tready;
    logic                        m_tlast;

    int checks;
    int errors;
    int timeouts;
    // reference counters, one per dimension
    int model_cnt [hdc_pkg::DIM];
    // expected store count, saturates at 255
    int store_total;

    clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    hdc_bundler dut (.*);

    task automatic check_word(input string name, input logic [hdc_pkg::WORD-1:0] got,
                              input logic [hdc_pkg::WORD-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    // model: bit 1 counts up, bit 0 counts down, clipped to the counter range
    task automatic model_store(input logic [hdc_pkg::DIM-1:0] v);
        for (int i = 0; i < hdc_pkg::DIM; i++) begin
            if (v[i] && (model_cnt[i] < CNT_HI)) begin
                model_cnt[i]++;
            end else if (!v[i] && (model_cnt[i] > CNT_LO)) begin
                model_cnt[i]--;
            end
        end
        if (store_total < 255) begin
            store_total++;
        end
    endtask

    task automatic model_clear();
        for (int i = 0; i < hdc_pkg::DIM; i++) begin
            model_cnt[i] = 0;
        end
    endtask

    // majority bit set only for a strictly positive count
    function automatic logic [hdc_pkg::DIM-1:0] model_sign();
        logic [hdc_pkg::DIM-1:0] s;
        for (int i = 0; i < hdc_pkg::DIM; i++) begin
            s[i] = (model_cnt[i] > 0);
        end
        return s;
    endfunction

    task automatic axil_write(input logic [axil_pkg::ADDR_W-1:0] addr,
                              input logic [hdc_pkg::WORD-1:0] data,
                              input logic [hdc_pkg::WORD/8-1:0] strb,
                              output logic [1:0] resp);
        int n;
        @(negedge clk);
        s_awaddr  = addr;
        s_awvalid = 1'b1;
        s_wdata   = data;
        s_wstrb   = strb;
        s_wvalid  = 1'b1;
        n = 0;
        // address and data are taken together
        do begin
            @(negedge clk);
            n++;
        end while (!s_awready && !s_wready && (n < TIMEOUT));
        if (!s_awready && !s_wready) begin
            timeouts++;
            $display("write to %h was never accepted", addr);
        end else begin
            check_bit("s_awready", s_awready, 1'b1);
            check_bit("s_wready", s_wready, 1'b1);
        end
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        n = 0;
        while (!s_bvalid && (n < TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        resp = s_bresp;
        if (!s_bvalid) begin
            timeouts++;
            $display("no write response for address %h", addr);
        end else begin
            // bvalid held until this
            s_bready = 1'b1;
            @(negedge clk);
            s_bready = 1'b0;
        end
    endtask

    task automatic axil_read(input logic [axil_pkg::ADDR_W-1:0] addr,
                             output logic [hdc_pkg::WORD-1:0] data,
                             output logic [1:0] resp);
        int n;
        @(negedge clk);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!s_arready && (n < TIMEOUT));
        if (!s_arready) begin
            timeouts++;
            $display("read of %h was never accepted", addr);
        end
        s_arvalid = 1'b0;
        n = 0;
        // latency depends on arbitration
        while (!s_rvalid && (n < TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        data = s_rdata;
        resp = s_rresp;
        if (!s_rvalid) begin
            timeouts++;
            $display("no read data for address %h", addr);
        end else begin
            s_rready = 1'b1;
            @(negedge clk);
            s_rready = 1'b0;
        end
    endtask

    // takes both beats under random stalls, checks data and last per beat
    task automatic stream_collect(input logic [hdc_pkg::DIM-1:0] exp_vec);
        int   n;
        int   beat;
        logic ready;
        n    = 0;
        beat = 0;
        while ((beat < hdc_pkg::NCHUNK) && (n < TIMEOUT)) begin
            @(negedge clk);
            n++;
            // roughly one stall in three
            ready    = (($urandom % 3) != 0);
            m_tready = ready;
            // handshake happens on the coming rising edge
            if (m_tvalid && ready) begin
                check_word($sformatf("m_tdata beat %0d", beat), m_tdata,
                           exp_vec[beat * hdc_pkg::WORD +: hdc_pkg::WORD]);
                check_bit($sformatf("m_tlast beat %0d", beat), m_tlast,
                          beat == hdc_pkg::NCHUNK - 1);
                beat++;
            end
        end
        if (beat < hdc_pkg::NCHUNK) begin
            timeouts++;
            $display("stream delivered only %0d of %0d beats", beat, hdc_pkg::NCHUNK);
        end
        @(negedge clk);
        m_tready = 1'b0;
    endtask

    // load both chunks, then one store
    task automatic store_vector(input logic [hdc_pkg::DIM-1:0] v);
        logic [1:0] r;
        axil_write(axil_pkg::A_DATA0, v[hdc_pkg::WORD-1:0], 4'hf, r);
        check_resp("s_bresp data0", r, axil_pkg::RESP_OKAY);
        axil_write(axil_pkg::A_DATA1, v[hdc_pkg::DIM-1:hdc_pkg::WORD], 4'hf, r);
        check_resp("s_bresp data1", r, axil_pkg::RESP_OKAY);
        axil_write(axil_pkg::A_CTRL, 32'h1, 4'hf, r);
        check_resp("s_bresp ctrl", r, axil_pkg::RESP_OKAY);
        model_store(v);
    endtask

    task automatic clear_counters();
        logic [1:0] r;
        axil_write(axil_pkg::A_CTRL, 32'h2, 4'hf, r);
        check_resp("s_bresp clear", r, axil_pkg::RESP_OKAY);
        model_clear();
    endtask

    task automatic check_signs(input logic [hdc_pkg::DIM-1:0] exp_vec);
        logic [hdc_pkg::WORD-1:0] d;
        logic [1:0]               r;
        axil_read(axil_pkg::A_SIGN0, d, r);
        check_resp("s_rresp sign0", r, axil_pkg::RESP_OKAY);
        check_word("sign0", d, exp_vec[hdc_pkg::WORD-1:0]);
        axil_read(axil_pkg::A_SIGN1, d, r);
        check_resp("s_rresp sign1", r, axil_pkg::RESP_OKAY);
        check_word("sign1", d, exp_vec[hdc_pkg::DIM-1:hdc_pkg::WORD]);
    endtask

    task automatic check_status(input logic busy_exp);
        logic [hdc_pkg::WORD-1:0] d;
        logic [1:0]               r;
        axil_read(axil_pkg::A_STATUS, d, r);
        check_resp("s_rresp status", r, axil_pkg::RESP_OKAY);
        check_word("status store count", 32'(d[15:8]), 32'(store_total));
        check_bit("status busy", d[0], busy_exp);
    endtask

    task automatic majority_of_three();
        logic [hdc_pkg::DIM-1:0] v;
        for (int k = 0; k < 3; k++) begin
            v = {$urandom, $urandom};
            store_vector(v);
        end
        check_signs(model_sign());
    endtask

    task automatic clear_keeps_count();
        clear_counters();
        check_signs('0);
        // store count survives a clear
        check_status(1'b0);
    endtask

    task automatic saturate_counters();
        clear_counters();
        for (int k = 0; k < 130; k++) begin
            store_vector('1);
        end
        // one step down from the top keeps every count positive
        store_vector('0);
        check_signs(model_sign());
        check_status(1'b0);
    endtask

    task automatic stream_under_stall();
        logic [1:0] r;
        // fresh vector so the two beats differ
        clear_counters();
        store_vector({$urandom, $urandom});
        axil_write(axil_pkg::A_CTRL, 32'h4, 4'hf, r);
        check_resp("s_bresp start", r, axil_pkg::RESP_OKAY);
        // m_tready low here, so the streamer sits on its first beat
        check_status(1'b1);
        stream_collect(model_sign());
        check_status(1'b0);
    endtask

    task automatic unmapped_access();
        logic [hdc_pkg::WORD-1:0] d;
        logic [1:0]               r;
        axil_write(8'h40, 32'hffff_ffff, 4'hf, r);
        check_resp("s_bresp unmapped", r, axil_pkg::RESP_SLVERR);
        axil_read(8'h40, d, r);
        check_resp("s_rresp unmapped", r, axil_pkg::RESP_SLVERR);
        check_signs(model_sign());
        check_status(1'b0);
    endtask

    // streamer and register reads compete for the bank
    task automatic stream_with_reads();
        logic [1:0] r;
        axil_write(axil_pkg::A_CTRL, 32'h4, 4'hf, r);
        check_resp("s_bresp start", r, axil_pkg::RESP_OKAY);
        fork
            stream_collect(model_sign());
            check_signs(model_sign());
        join
        check_status(1'b0);
    endtask

    initial begin
        int n;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        store_total = 0;
        s_awaddr    = '0;
        s_awvalid   = 1'b0;
        s_wdata     = '0;
        s_wstrb     = '0;
        s_wvalid    = 1'b0;
        s_bready    = 1'b0;
        s_araddr    = '0;
        s_arvalid   = 1'b0;
        s_rready    = 1'b0;
        m_tready    = 1'b0;
        void'($urandom(32'hf842_fd8d));
        model_clear();

        n = 0;
        while ((rst_n !== 1'b1) && (n < TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("reset was never released");
        end

        majority_of_three();
        clear_keeps_count();
        saturate_counters();
        stream_under_stall();
        unmapped_access();
        stream_with_reads();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over five rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: design/hdc_bundler.sv
`default_nettype none

module hdc_bundler (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [axil_pkg::ADDR_W-1:0] s_awaddr,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    input  logic [hdc_pkg::WORD-1:0]    s_wdata,
    input  logic [hdc_pkg::WORD/8-1:0]  s_wstrb,
    input  logic                        s_wvalid,
    output logic                        s_wready,
    output logic [1:0]                  s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready,
    input  logic [axil_pkg::ADDR_W-1:0] s_araddr,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    output logic [hdc_pkg::WORD-1:0]    s_rdata,
    output logic [1:0]                  s_rresp,
    output logic                        s_rvalid,
    input  logic                        s_rready,
    output logic [hdc_pkg::WORD-1:0]    m_tdata,
    output logic                        m_tvalid,
    input  logic                        m_tready,
    output logic                        m_tlast
);

    // register side, stream side, and the bank port
    acc_bus_if regs_bus ();
    acc_bus_if strm_bus ();
    acc_bus_if bank_bus ();

    logic stream_start;
    logic stream_busy;

    axil_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .s_awaddr     (s_awaddr),
        .s_awvalid    (s_awvalid),
        .s_awready    (s_awready),
        .s_wdata      (s_wdata),
        .s_wstrb      (s_wstrb),
        .s_wvalid     (s_wvalid),
        .s_wready     (s_wready),
        .s_bresp      (s_bresp),
        .s_bvalid     (s_bvalid),
        .s_bready     (s_bready),
        .s_araddr     (s_araddr),
        .s_arvalid    (s_arvalid),
        .s_arready    (s_arready),
        .s_rdata      (s_rdata),
        .s_rresp      (s_rresp),
        .s_rvalid     (s_rvalid),
        .s_rready     (s_rready),
        .bus          (regs_bus.initiator),
        .stream_start (stream_start),
        .stream_busy  (stream_busy)
    );

    vector_streamer u_streamer (
        .clk          (clk),
        .rst_n        (rst_n),
        .stream_start (stream_start),
        .stream_busy  (stream_busy),
        .bus          (strm_bus.initiator),
        .m_tdata      (m_tdata),
        .m_tvalid     (m_tvalid),
        .m_tready     (m_tready),
        .m_tlast      (m_tlast)
    );

    acc_arbiter u_arbiter (
        .init0 (regs_bus.target),
        .init1 (strm_bus.target),
        .tgt   (bank_bus.initiator),
        .clk   (clk),
        .rst_n (rst_n)
    );

    bundle_bank u_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bank_bus.target)
    );

endmodule

`default_nettype wire

// File: design/vector_streamer.sv
`default_nettype none

module vector_streamer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stream_start,
    output logic                     stream_busy,
    acc_bus_if.initiator             bus,
    output logic [hdc_pkg::WORD-1:0] m_tdata,
    output logic                     m_tvalid,
    input  logic                     m_tready,
    output logic                     m_tlast
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_FETCH = 2'd1;
    localparam logic [1:0] S_EMIT  = 2'd2;

    logic [1:0]                  state;
    logic [hdc_pkg::CHUNK_W-1:0] idx;
    // read granted, data lands next cycle
    logic                        got;

    assign stream_busy = (state != S_IDLE);

    // no request while a beat waits on m_tready
    assign bus.req   = (state == S_FETCH) && !got;
    assign bus.op    = hdc_pkg::OP_READ;
    assign bus.idx   = idx;
    assign bus.wdata = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            idx      <= '0;
            got      <= 1'b0;
            m_tvalid <= 1'b0;
            m_tlast  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (stream_start) begin
                        idx   <= '0;
                        state <= S_FETCH;
                    end
                end

                S_FETCH: begin
                    if (got) begin
                        // capture sign chunk into the output beat
                        got      <= 1'b0;
                        m_tdata  <= bus.rdata;
                        m_tvalid <= 1'b1;
                        m_tlast  <= (idx == hdc_pkg::LAST_CHUNK);
                        state    <= S_EMIT;
                    end else if (bus.gnt) begin
                        got <= 1'b1;
                    end
                end

                S_EMIT: begin
                    // beat held until the sink takes it
                    if (m_tready) begin
                        m_tvalid <= 1'b0;
                        m_tlast  <= 1'b0;
                        if (m_tlast) begin
                            state <= S_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= S_FETCH;
                        end
                    end
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/axil_regs.sv
`default_nettype none

module axil_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [axil_pkg::ADDR_W-1:0] s_awaddr,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    input  logic [hdc_pkg::WORD-1:0]    s_wdata,
    input  logic [hdc_pkg::WORD/8-1:0]  s_wstrb,
    input  logic                        s_wvalid,
    output logic                        s_wready,
    output logic [1:0]                  s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready,
    input  logic [axil_pkg::ADDR_W-1:0] s_araddr,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    output logic [hdc_pkg::WORD-1:0]    s_rdata,
    output logic [1:0]                  s_rresp,
    output logic                        s_rvalid,
    input  logic                        s_rready,
    acc_bus_if.initiator                bus,
    output logic                        stream_start,
    input  logic                        stream_busy
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_WOP   = 3'd1;
    localparam logic [2:0] S_BRESP = 3'd2;
    localparam logic [2:0] S_ROP   = 3'd3;
    localparam logic [2:0] S_RDATA = 3'd4;
    localparam logic [2:0] S_RRESP = 3'd5;

    logic [2:0]                  state;
    // pending bus ops, bit 0 load, bit 1 clear, bit 2 store
    logic [2:0]                  pend;
    // pending ops once the lowest one is granted
    logic [2:0]                  pend_rest;
    logic                        do_start;
    // address of the transaction in flight, read or write
    logic [axil_pkg::ADDR_W-1:0] addr;
    logic [hdc_pkg::WORD-1:0]    wdata;
    logic [7:0]                  store_cnt;
    logic                        rd_sign;

    assign pend_rest = pend & (pend - 3'd1);
    assign rd_sign   = (addr == axil_pkg::A_SIGN0) || (addr == axil_pkg::A_SIGN1);

    // bus request straight from state, held until gnt
    assign bus.req   = ((state == S_WOP) && (pend != '0)) || ((state == S_ROP) && rd_sign);
    // DATA1 and SIGN1 sit one word above chunk 0
    assign bus.idx   = addr[2 +: hdc_pkg::CHUNK_W];
    assign bus.wdata = wdata;

    // load first, then clear, then store
    always_comb begin
        if (state == S_ROP) begin
            bus.op = hdc_pkg::OP_READ;
        end else if (pend[0]) begin
            bus.op = hdc_pkg::OP_LOAD;
        end else if (pend[1]) begin
            bus.op = hdc_pkg::OP_CLEAR;
        end else begin
            bus.op = hdc_pkg::OP_STORE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            pend         <= '0;
            do_start     <= 1'b0;
            store_cnt    <= '0;
            s_awready    <= 1'b0;
            s_wready     <= 1'b0;
            s_arready    <= 1'b0;
            s_bvalid     <= 1'b0;
            s_rvalid     <= 1'b0;
            s_bresp      <= axil_pkg::RESP_OKAY;
            s_rresp      <= axil_pkg::RESP_OKAY;
            stream_start <= 1'b0;
        end else begin
            // single-cycle pulses
            s_awready    <= 1'b0;
            s_wready     <= 1'b0;
            s_arready    <= 1'b0;
            stream_start <= 1'b0;

            // saturating store count
            if (bus.gnt && (bus.op == hdc_pkg::OP_STORE) && (store_cnt != 8'hff)) begin
                store_cnt <= store_cnt + 8'd1;
            end

            case (state)
                S_IDLE: begin
                    // write wins over read when both arrive
                    if (s_awvalid && s_wvalid) begin
                        s_awready <= 1'b1;
                        s_wready  <= 1'b1;
                        addr      <= s_awaddr;
                        wdata     <= s_wdata;
                        s_bresp   <= axil_pkg::RESP_OKAY;
                        pend      <= '0;
                        do_start  <= 1'b0;
                        case (s_awaddr)
                            axil_pkg::A_DATA0, axil_pkg::A_DATA1: begin
                                pend <= {2'b00, |s_wstrb};
                            end
                            axil_pkg::A_CTRL: begin
                                // ctrl bits live in byte 0
                                pend <= {s_wdata[axil_pkg::CTRL_STORE],
                                         s_wdata[axil_pkg::CTRL_CLEAR],
                                         1'b0} & {3{s_wstrb[0]}};
                                do_start <= s_wdata[axil_pkg::CTRL_START] & s_wstrb[0];
                            end
                            default: begin
                                s_bresp <= axil_pkg::RESP_SLVERR;
                            end
                        endcase
                        state <= S_WOP;
                    end else if (s_arvalid) begin
                        s_arready <= 1'b1;
                        addr      <= s_araddr;
                        state     <= S_ROP;
                    end
                end

                S_WOP: begin
                    // done when nothing was queued or the last op is granted
                    if ((pend == '0) || (bus.gnt && (pend_rest == '0))) begin
                        pend         <= '0;
                        s_bvalid     <= 1'b1;
                        stream_start <= do_start;
                        state        <= S_BRESP;
                    end else if (bus.gnt) begin
                        pend <= pend_rest;
                    end
                end

                S_BRESP: begin
                    if (s_bready) begin
                        s_bvalid <= 1'b0;
                        state    <= S_IDLE;
                    end
                end

                S_ROP: begin
                    // status and unmapped answer locally
                    if (!rd_sign) begin
                        s_rvalid <= 1'b1;
                        state    <= S_RRESP;
                        if (addr == axil_pkg::A_STATUS) begin
                            s_rdata <= {16'h0000, store_cnt, 7'b0000000, stream_busy};
                            s_rresp <= axil_pkg::RESP_OKAY;
                        end else begin
                            s_rdata <= '0;
                            s_rresp <= axil_pkg::RESP_SLVERR;
                        end
                    end else if (bus.gnt) begin
                        state <= S_RDATA;
                    end
                end

                S_RDATA: begin
                    // bank data valid this cycle
                    s_rdata  <= bus.rdata;
                    s_rresp  <= axil_pkg::RESP_OKAY;
                    s_rvalid <= 1'b1;
                    state    <= S_RRESP;
                end

                S_RRESP: begin
                    if (s_rready) begin
                        s_rvalid <= 1'b0;
                        state    <= S_IDLE;
                    end
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/acc_arbiter.sv
`default_nettype none

module acc_arbiter (
    acc_bus_if.target    init0,
    acc_bus_if.target    init1,
    acc_bus_if.initiator tgt,
    input  logic         clk,
    input  logic         rst_n
);

    // favoured initiator on a tie
    logic prio;
    // selected initiator, 1 is init1
    logic sel;

    // tie goes to prio, otherwise whoever asks
    assign sel = (init0.req && init1.req) ? prio : init1.req;

    assign tgt.req   = init0.req || init1.req;
    assign tgt.op    = sel ? init1.op    : init0.op;
    assign tgt.idx   = sel ? init1.idx   : init0.idx;
    assign tgt.wdata = sel ? init1.wdata : init0.wdata;

    // grant routed back to the selected side only
    assign init0.gnt = tgt.gnt && !sel;
    assign init1.gnt = tgt.gnt && sel;

    // read data fans out, each side samples after its own grant
    assign init0.rdata = tgt.rdata;
    assign init1.rdata = tgt.rdata;

    // flip priority to the other side after each grant
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio <= 1'b0;
        end else if (tgt.gnt) begin
            prio <= !sel;
        end
    end

endmodule

`default_nettype wire

// File: design/bundle_bank.sv
`default_nettype none

module bundle_bank (
    input  logic      clk,
    input  logic      rst_n,
    acc_bus_if.target bus
);

    // staged input vector, filled chunk by chunk
    logic [hdc_pkg::DIM-1:0] stage;
    // majority vector, one sign bit per counter
    logic [hdc_pkg::DIM-1:0] sign;
    // operation accepted this cycle
    logic                    fire;
    logic                    do_store;
    logic                    do_clear;

    assign fire     = bus.req && bus.gnt;
    assign do_store = fire && (bus.op == hdc_pkg::OP_STORE);
    assign do_clear = fire && (bus.op == hdc_pkg::OP_CLEAR);

    // grant one cycle after req, never back to back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.gnt <= 1'b0;
        end else begin
            bus.gnt <= bus.req && !bus.gnt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage <= '0;
        end else if (fire && (bus.op == hdc_pkg::OP_LOAD)) begin
            stage[bus.idx * hdc_pkg::WORD +: hdc_pkg::WORD] <= bus.wdata;
        end
    end

    // one saturating up/down counter per dimension
    for (genvar i = 0; i < hdc_pkg::DIM; i++) begin : g_dim
        logic signed [hdc_pkg::CNT_W-1:0] cnt;

        always_ff @(posedge clk) begin
            if (!rst_n || do_clear) begin
                cnt <= '0;
            end else if (do_store) begin
                // bit 1 counts up, bit 0 counts down
                if (stage[i] && (cnt != hdc_pkg::CNT_MAX)) begin
                    cnt <= cnt + hdc_pkg::CNT_W'(1);
                end else if (!stage[i] && (cnt != hdc_pkg::CNT_MIN)) begin
                    cnt <= cnt - hdc_pkg::CNT_W'(1);
                end
            end
        end

        // strictly positive gives a one
        assign sign[i] = !cnt[hdc_pkg::CNT_W-1] && (cnt != '0);
    end

    // registered chunk read of the sign bits
    always_ff @(posedge clk) begin
        if (fire && (bus.op == hdc_pkg::OP_READ)) begin
            bus.rdata <= sign[bus.idx * hdc_pkg::WORD +: hdc_pkg::WORD];
        end
    end

endmodule

`default_nettype wire

// File: design/acc_bus_if.sv
`default_nettype none

interface acc_bus_if;

    // request side, held until gnt
    logic                        req;
    hdc_pkg::acc_op_e            op;
    logic [hdc_pkg::CHUNK_W-1:0] idx;
    logic [hdc_pkg::WORD-1:0]    wdata;

    // one-cycle grant, op takes effect on that edge
    logic                        gnt;
    // read data, valid the cycle after gnt
    logic [hdc_pkg::WORD-1:0]    rdata;

    modport initiator (
        output req, op, idx, wdata,
        input  gnt, rdata
    );

    modport target (
        input  req, op, idx, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

// File: design/axil_pkg.sv
`default_nettype none

package axil_pkg;

    localparam int ADDR_W = 8;

    // register map, byte addresses
    localparam logic [ADDR_W-1:0] A_DATA0  = 8'h00;
    localparam logic [ADDR_W-1:0] A_DATA1  = 8'h04;
    localparam logic [ADDR_W-1:0] A_CTRL   = 8'h10;
    localparam logic [ADDR_W-1:0] A_SIGN0  = 8'h20;
    localparam logic [ADDR_W-1:0] A_SIGN1  = 8'h24;
    localparam logic [ADDR_W-1:0] A_STATUS = 8'h30;

    // CTRL bit positions
    localparam int CTRL_STORE = 0;
    localparam int CTRL_CLEAR = 1;
    localparam int CTRL_START = 2;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: design/hdc_pkg.sv
`default_nettype none

package hdc_pkg;

    // hypervector geometry
    localparam int DIM     = 64;
    localparam int WORD    = 32;
    localparam int NCHUNK  = DIM / WORD;
    localparam int CHUNK_W = 1;

    // index of the final chunk of a vector
    localparam logic [CHUNK_W-1:0] LAST_CHUNK = CHUNK_W'(NCHUNK - 1);

    // per-dimension counter, two's complement
    localparam int CNT_W = 8;
    localparam logic signed [CNT_W-1:0] CNT_MAX = {1'b0, {(CNT_W-1){1'b1}}};
    localparam logic signed [CNT_W-1:0] CNT_MIN = {1'b1, {(CNT_W-1){1'b0}}};

    // operations on the shared counter-bank bus
    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_CLEAR = 2'd2,
        OP_READ  = 2'd3
    } acc_op_e;

endpackage

`default_nettype wire
